// ==== sources.f ====
+incdir+tb
source/bwt_pkg.sv
source/fwd_entry_stage.sv
source/hit_check_stage.sv
source/ik_update_stage.sv
source/break_flush_stage.sv
source/mem_request_stage.sv
source/bwt_fwd_datapath.sv
tb/tb_bwt_fwd_datapath.sv

// ==== Bender.yml ====
package:
  name: bwt_fwd_datapath

sources:
  - files:
      - source/bwt_pkg.sv
      - source/fwd_entry_stage.sv
      - source/hit_check_stage.sv
      - source/ik_update_stage.sv
      - source/break_flush_stage.sv
      - source/mem_request_stage.sv
      - source/bwt_fwd_datapath.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_bwt_fwd_datapath.sv

// ==== tb/fwd_vectors.svh ====
`ifndef FWD_VECTORS_SVH
`define FWD_VECTORS_SVH

// columns: status, query, ptr_curr, forward_i, min_intv, ik.x2, picked candidate x2
// x0, x1, info, read_num and the unpicked candidates are random

task automatic load_vectors();
	logic [7:0]  rnd_q;
	logic [6:0]  rnd_i;
	logic [63:0] rnd_x2;
	// interval update, base 0 takes candidate 3
	add_row(bwt_pkg::F_RUN,   8'd0, 7'd5,  7'd10,  7'd3,  64'd40,  64'd20);
	add_row(bwt_pkg::F_RUN,   8'd2, 7'd9,  7'd50,  7'd3,  64'd100, 64'd64);
	add_row(bwt_pkg::F_RUN,   8'd1, 7'd14, 7'd22,  7'd4,  64'd30,  64'd4);  // x2 == min
	add_row(bwt_pkg::F_RUN,   8'd3, 7'd0,  7'd100, 7'd1,  64'd9,   64'd8);  // reaches 101
	// break on a small interval or an ambiguous base
	add_row(bwt_pkg::F_RUN,   8'd1, 7'd12, 7'd20,  7'd8,  64'd30,  64'd5);
	add_row(bwt_pkg::F_RUN,   8'd4, 7'd3,  7'd7,   7'd2,  64'd30,  64'd30);
	add_row(bwt_pkg::F_RUN,   8'd2, 7'd7,  7'd100, 7'd10, 64'd12,  64'd9);  // no flush
	// unchanged interval
	add_row(bwt_pkg::F_RUN,   8'd3, 7'd20, 7'd33,  7'd2,  64'd17,  64'd17);
	// end of read
	add_row(bwt_pkg::F_RUN,   8'd0, 7'd40, 7'd101, 7'd2,  64'd25,  64'd11);
	add_row(bwt_pkg::F_RUN,   8'd1, 7'd41, 7'd110, 7'd2,  64'd25,  64'd11);
	// status pass-through
	add_row(bwt_pkg::F_INIT,  8'd2, 7'd0,  7'd0,   7'd1,  64'd90,  64'd3);
	add_row(bwt_pkg::B_RUN,   8'd0, 7'd6,  7'd15,  7'd2,  64'd44,  64'd2);
	add_row(bwt_pkg::DONE,    8'd1, 7'd8,  7'd18,  7'd2,  64'd44,  64'd2);
	// random bases and candidate sizes
	repeat (3) begin
		rnd_q  = 8'($random(seed) & 3);
		rnd_i  = 7'($random(seed) & 63);
		rnd_x2 = 64'($random(seed) & 32'h7f);
		add_row(bwt_pkg::F_RUN, rnd_q, 7'd30, rnd_i, 7'd8, 64'd60, rnd_x2);
	end
endtask

`endif

// ==== tb/tb_bwt_fwd_datapath.sv ====
`default_nettype none

module tb_bwt_fwd_datapath;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned READ_LEN   = 101;                    // bases per read
	localparam int          RST_CYCLES = 16;                     // reset held low
	localparam int          WAIT_LIMIT = 64;                     // slack cycles per wait
	localparam logic [63:0] PRIMARY    = 64'h0000_0000_8000_0000; // row of the $ suffix

	// expected outputs of one record
	typedef struct packed {
		bwt_pkg::ext_rec_t  rec;
		bwt_pkg::dram_req_t dram;
		bwt_pkg::curr_wr_t  curr1;
		bwt_pkg::curr_wr_t  curr2;
	} exp_t;

	logic                       Clk_32UI = 1'b0;
	logic                       reset_BWT_extend;
	bwt_pkg::ext_rec_t          rec_i;
	bwt_pkg::cand_set_t         cand_i;
	logic [bwt_pkg::WORD_W-1:0] primary_i;
	bwt_pkg::ext_rec_t          rec_o;
	bwt_pkg::dram_req_t         dram_o;
	bwt_pkg::curr_wr_t          curr1_o;
	bwt_pkg::curr_wr_t          curr2_o;

	bwt_pkg::ext_rec_t  vec_rec[$];   // stimulus table
	bwt_pkg::cand_set_t vec_cand[$];
	exp_t               vec_exp[$];   // filled by the reference model
	bwt_pkg::ext_rec_t  idle_rec;     // empty slot between records
	int                 seed;
	int                 n_checks;
	int                 n_errors;
	int                 n_rows_done;  // records seen at rec_o

	bwt_fwd_datapath #(.READ_LEN(READ_LEN)) dut (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.rec_i            (rec_i),
		.cand_i           (cand_i),
		.primary_i        (primary_i),
		.rec_o            (rec_o),
		.dram_o           (dram_o),
		.curr1_o          (curr1_o),
		.curr2_o          (curr2_o)
	);

	always #20 Clk_32UI = ~Clk_32UI; // 40 ns period

	task automatic compare(input string name, input int row,
		input logic [319:0] got, input logic [319:0] want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("error %s row %0d: got %h expected %h", name, row, got, want);
		end
	endtask

	// x1 of a row: low bits put k or l on an occ block edge, bit 31 moves it across primary
	function automatic logic [63:0] edge_x1(input int row, input logic [63:0] x2,
		input logic [31:0] rnd);
		logic [63:0] x1;
		x1     = {32'h0, rnd};
		x1[31] = row[1];                               // two rows below, two above
		case (row % 3)
			0:       x1[6:0] = 7'd0;                   // x1 - 1 borrows into the block
			1:       x1[6:0] = 7'd1;                   // k ends in zeros
			default: x1[6:0] = 7'd1 - x2[6:0];         // l ends in zeros
		endcase
		return x1;
	endfunction

	// one table row, random payload around the fields that steer the datapath
	task automatic add_row(input bwt_pkg::fwd_status_e st, input logic [7:0] query,
		input logic [6:0] ptr, input logic [6:0] fwd_i, input logic [6:0] min_intv,
		input logic [63:0] ik_x2, input logic [63:0] pick_x2);
		bwt_pkg::ext_rec_t  r;
		bwt_pkg::cand_set_t c;
		int                 b;
		r           = '0;
		r.status    = st;
		r.query     = query;
		r.ptr_curr  = ptr;
		r.forward_i = fwd_i;
		r.min_intv  = min_intv;
		r.read_num  = 10'($random(seed));
		r.ik.x0     = {32'h0, 32'($random(seed))};
		r.ik.x1     = edge_x1(vec_rec.size(), ik_x2, 32'($random(seed))); // -1 steps visible
		r.ik.x2     = ik_x2;
		r.ik.info   = 64'($random(seed) & 32'hff);
		for (b = 0; b < 4; b++) begin
			c[b].x0 = {32'h0, 32'($random(seed))};
			c[b].x1 = {32'h0, 32'($random(seed))};
			c[b].x2 = 64'($random(seed) & 32'hff);   // unused unless picked
		end
		if (query <= 8'd3) begin
			c[3 - query].x2 = pick_x2;               // complemented base
			c[3 - query].x1 = edge_x1(vec_rec.size(), pick_x2, c[3 - query].x1[31:0]);
		end
		vec_rec.push_back(r);
		vec_cand.push_back(c);
	endtask

`include "fwd_vectors.svh"

	// ------------------------------------------------------------------
	// reference model, one record through all five steps
	// ------------------------------------------------------------------
	function automatic exp_t model_row(input bwt_pkg::ext_rec_t r,
		input bwt_pkg::cand_set_t c, input logic [63:0] primary);
		exp_t           e;
		bwt_pkg::cand_t cd;
		logic [63:0]    k;
		logic [63:0]    l;
		e  = '0;
		cd = '0;
		if (r.status == bwt_pkg::F_RUN && r.forward_i >= READ_LEN) begin
			r.status = bwt_pkg::F_BREAK;               // past the read end
		end
		if (r.status == bwt_pkg::F_RUN) begin
			if (r.query <= 8'd3) begin
				cd = c[3 - r.query];
			end
			if (r.query > 8'd3 || cd.x2 != r.ik.x2) begin
				e.curr1.we   = 1'b1;                   // old interval saved
				e.curr1.addr = r.ptr_curr;
				e.curr1.data = r.ik;
				r.ptr_curr   = r.ptr_curr + 7'd1;
				if (r.query > 8'd3 || cd.x2 < r.min_intv) begin
					r.status = bwt_pkg::F_BREAK;
				end else begin
					r.ik.x0     = cd.x0;
					r.ik.x1     = cd.x1;
					r.ik.x2     = cd.x2;
					r.ik.info   = 64'(r.forward_i) + 64'd1;
					r.forward_i = r.forward_i + 7'd1;
				end
			end
		end
		if (r.status == bwt_pkg::F_BREAK) begin
			r.status = bwt_pkg::B_INIT;                // handed to backward search
			if (r.forward_i == READ_LEN) begin
				e.curr2.we   = 1'b1;                   // end of read flush
				e.curr2.addr = r.ptr_curr;
				e.curr2.data = r.ik;
				r.ptr_curr   = r.ptr_curr + 7'd1;
			end
		end
		k = r.ik.x1 - 64'd1;
		l = k + r.ik.x2;
		if (k >= primary) k = k - 64'd1;               // skip the $ row
		if (l >= primary) l = l - 64'd1;
		if (r.status == bwt_pkg::F_INIT || r.status == bwt_pkg::F_RUN) begin
			e.dram.valid  = 1'b1;
			e.dram.addr_k = {k[34:7], 4'b0000};
			e.dram.addr_l = {l[34:7], 4'b0000};
		end
		if (r.status == bwt_pkg::F_INIT) r.status = bwt_pkg::F_RUN;
		e.rec = r;
		return e;
	endfunction

	task automatic drive_slot(input int t);
		if (t < vec_rec.size()) begin
			rec_i  <= vec_rec[t];
			cand_i <= vec_cand[t];
		end else begin
			rec_i  <= idle_rec;                        // drain with empty slots
			cand_i <= '0;
		end
	endtask

	// port 1 two slots back, port 2 four, record and request five
	task automatic check_slot(input int t);
		int r1;
		int r2;
		int r5;
		r1 = t - 2;
		r2 = t - 4;
		r5 = t - 5;
		if (r1 >= 0 && r1 < vec_exp.size()) compare("curr1_o", r1, curr1_o, vec_exp[r1].curr1);
		else compare("curr1_o", -1, curr1_o, '0);
		if (r2 >= 0 && r2 < vec_exp.size()) compare("curr2_o", r2, curr2_o, vec_exp[r2].curr2);
		else compare("curr2_o", -1, curr2_o, '0);
		if (r5 >= 0 && r5 < vec_exp.size()) begin
			compare("rec_o", r5, rec_o, vec_exp[r5].rec);
			compare("dram_o", r5, dram_o, vec_exp[r5].dram);
			n_rows_done++;
		end else begin
			compare("rec_o.status", -1, rec_o.status, bwt_pkg::DONE);
			compare("dram_o", -1, dram_o, '0);
		end
	endtask

	// ------------------------------------------------------------------
	// reset, stimulus and report
	// ------------------------------------------------------------------
	initial begin
		reset_BWT_extend = 1'b0;
		for (int c = 0; c < RST_CYCLES; c++) @(posedge Clk_32UI);
		reset_BWT_extend <= 1'b1;
	end

	initial begin
		int   wait_cnt;
		int   step;
		logic released;
		seed        = 3591;
		n_checks    = 0;
		n_errors    = 0;
		n_rows_done = 0;
		idle_rec        = '0;
		idle_rec.status = bwt_pkg::DONE;
		rec_i     = idle_rec;
		cand_i    = '0;
		primary_i = PRIMARY;                           // fixed for the whole run
		load_vectors();
		foreach (vec_rec[i]) vec_exp.push_back(model_row(vec_rec[i], vec_cand[i], PRIMARY));
		released = 1'b0;
		wait_cnt = 0;
		while (!released && wait_cnt < RST_CYCLES + WAIT_LIMIT) begin
			@(posedge Clk_32UI);
			wait_cnt++;
			released = (reset_BWT_extend === 1'b1);
			if (!released) begin
				@(negedge Clk_32UI);
				check_slot(-100);                      // every control idle in reset
			end
		end
		if (!released) begin
			$display("timeout: reset was never released");
			n_errors++;
		end else begin
			step = 0;
			while (n_rows_done < vec_rec.size() && step < vec_rec.size() + WAIT_LIMIT) begin
				drive_slot(step);
				@(negedge Clk_32UI);                   // outputs settled
				check_slot(step);
				@(posedge Clk_32UI);
				step++;
			end
			if (n_rows_done < vec_rec.size()) begin
				$display("timeout: pipeline did not drain, %0d of %0d records came out",
					n_rows_done, vec_rec.size());
				n_errors++;
			end
		end
		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/bwt_fwd_datapath.sv ====
`default_nettype none

module bwt_fwd_datapath #(
	parameter int unsigned READ_LEN = 101 // read length shared by the bound checks
) (
	input  wire                         Clk_32UI,
	input  wire                         reset_BWT_extend, // sync, active low
	input  bwt_pkg::ext_rec_t           rec_i,
	input  bwt_pkg::cand_set_t          cand_i,     // extended intervals per base
	input  wire [bwt_pkg::WORD_W-1:0]   primary_i,
	output bwt_pkg::ext_rec_t           rec_o,
	output bwt_pkg::dram_req_t          dram_o,
	output bwt_pkg::curr_wr_t           curr1_o,    // interval change writes
	output bwt_pkg::curr_wr_t           curr2_o     // end of read flush
);

	// ------------------------------------------------------------------
	// stage to stage signals
	// ------------------------------------------------------------------
	bwt_pkg::ext_rec_t          rec_s1;   // after entry
	bwt_pkg::ext_rec_t          rec_s2;   // after hit check
	bwt_pkg::ext_rec_t          rec_s3;   // after ik update
	bwt_pkg::ext_rec_t          rec_s4;   // after break flush
	bwt_pkg::cand_set_t         cand_s1;
	bwt_pkg::cand_t             pick_s2;
	logic                       upd_s2;
	logic [bwt_pkg::WORD_W-1:0] k_s4;
	logic [bwt_pkg::WORD_W-1:0] l_s4;

	fwd_entry_stage #(.READ_LEN(READ_LEN)) u_entry (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.rec_i            (rec_i),
		.cand_i           (cand_i),
		.rec_o            (rec_s1),
		.cand_o           (cand_s1)
	);

	hit_check_stage u_hit (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.rec_i            (rec_s1),
		.cand_i           (cand_s1),
		.rec_o            (rec_s2),
		.pick_o           (pick_s2),
		.update_o         (upd_s2),
		.curr_o           (curr1_o)
	);

	ik_update_stage u_upd (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.rec_i            (rec_s2),
		.pick_i           (pick_s2),
		.update_i         (upd_s2),
		.rec_o            (rec_s3)
	);

	break_flush_stage #(.READ_LEN(READ_LEN)) u_flush (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.rec_i            (rec_s3),
		.primary_i        (primary_i),
		.rec_o            (rec_s4),
		.curr_o           (curr2_o),
		.fwd_k_o          (k_s4),
		.fwd_l_o          (l_s4)
	);

	mem_request_stage u_mem (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.rec_i            (rec_s4),
		.fwd_k_i          (k_s4),
		.fwd_l_i          (l_s4),
		.rec_o            (rec_o),
		.dram_o           (dram_o)
	);

endmodule

`default_nettype wire

// ==== source/mem_request_stage.sv ====
`default_nettype none

module mem_request_stage (
	input  wire                         Clk_32UI,
	input  wire                         reset_BWT_extend, // sync, active low
	input  bwt_pkg::ext_rec_t           rec_i,
	input  wire [bwt_pkg::WORD_W-1:0]   fwd_k_i,
	input  wire [bwt_pkg::WORD_W-1:0]   fwd_l_i,
	output bwt_pkg::ext_rec_t           rec_o,
	output bwt_pkg::dram_req_t          dram_o
);

	bwt_pkg::ext_rec_t  rec_nxt;
	bwt_pkg::dram_req_t req_nxt;

	// ------------------------------------------------------------------
	// occ fetch for records still extending forward
	// ------------------------------------------------------------------
	always_comb begin
		rec_nxt = rec_i;
		req_nxt = '0; // broken or backward records fetch nothing
		if ((rec_i.status == bwt_pkg::F_INIT) || (rec_i.status == bwt_pkg::F_RUN)) begin
			req_nxt.valid  = 1'b1;
			req_nxt.addr_k = {fwd_k_i[34:7], 4'b0000}; // 128 rows per occ block
			req_nxt.addr_l = {fwd_l_i[34:7], 4'b0000};
		end
		if (rec_i.status == bwt_pkg::F_INIT) begin
			rec_nxt.status = bwt_pkg::F_RUN; // first pass only sets up the fetch
		end
	end

	always_ff @(posedge Clk_32UI) begin
		rec_o <= rec_nxt;
		if (!reset_BWT_extend) begin
			rec_o.status <= bwt_pkg::DONE;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			dram_o <= '0;
		end else begin
			dram_o <= req_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== source/break_flush_stage.sv ====
`default_nettype none

module break_flush_stage #(
	parameter int unsigned READ_LEN = 101
) (
	input  wire                         Clk_32UI,
	input  wire                         reset_BWT_extend, // sync, active low
	input  bwt_pkg::ext_rec_t           rec_i,
	input  wire [bwt_pkg::WORD_W-1:0]   primary_i,        // fixed per index
	output bwt_pkg::ext_rec_t           rec_o,
	output bwt_pkg::curr_wr_t           curr_o,           // curr queue port 2
	output logic [bwt_pkg::WORD_W-1:0]  fwd_k_o,
	output logic [bwt_pkg::WORD_W-1:0]  fwd_l_o
);

	bwt_pkg::ext_rec_t          rec_nxt;
	bwt_pkg::curr_wr_t          wr_nxt;
	logic [bwt_pkg::WORD_W-1:0] k_raw;  // start row before primary fix
	logic [bwt_pkg::WORD_W-1:0] l_raw;  // end row before primary fix
	logic [bwt_pkg::WORD_W-1:0] k_adj;
	logic [bwt_pkg::WORD_W-1:0] l_adj;

	// ------------------------------------------------------------------
	// end of read flush and hand over to backward phase
	// ------------------------------------------------------------------
	always_comb begin
		rec_nxt = rec_i;
		wr_nxt  = '0;
		if (rec_i.status == bwt_pkg::F_BREAK) begin
			rec_nxt.status = bwt_pkg::B_INIT;            // backward phase picks it up
			if (rec_i.forward_i == READ_LEN) begin
				wr_nxt.we        = 1'b1;                 // last interval of the read
				wr_nxt.addr      = rec_i.ptr_curr;
				wr_nxt.data      = rec_i.ik;
				rec_nxt.ptr_curr = rec_i.ptr_curr + 1'b1;
			end
		end
	end

	// k/l rows for the next occ lookup
	assign k_raw = rec_i.ik.x1 - 1'b1;
	assign l_raw = k_raw + rec_i.ik.x2;
	assign k_adj = (k_raw >= primary_i) ? k_raw - 1'b1 : k_raw; // skip the $ row
	assign l_adj = (l_raw >= primary_i) ? l_raw - 1'b1 : l_raw;

	always_ff @(posedge Clk_32UI) begin
		rec_o <= rec_nxt;
		if (!reset_BWT_extend) begin
			rec_o.status <= bwt_pkg::DONE;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			curr_o <= '0;          // no flush in reset
		end else begin
			curr_o <= wr_nxt;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		fwd_k_o <= k_adj;          // aligned with rec_o
		fwd_l_o <= l_adj;
	end

endmodule

`default_nettype wire

// ==== source/ik_update_stage.sv ====
`default_nettype none

module ik_update_stage (
	input  wire                     Clk_32UI,
	input  wire                     reset_BWT_extend, // sync, active low
	input  bwt_pkg::ext_rec_t       rec_i,
	input  bwt_pkg::cand_t          pick_i,
	input  wire                     update_i,
	output bwt_pkg::ext_rec_t       rec_o
);

	bwt_pkg::ext_rec_t rec_nxt;

	// ------------------------------------------------------------------
	// ik = ok[c], info = i + 1, i++
	// ------------------------------------------------------------------
	always_comb begin
		rec_nxt = rec_i; // default keeps old interval
		if (update_i && (rec_i.status == bwt_pkg::F_RUN)) begin
			rec_nxt.ik.x0     = pick_i.x0;
			rec_nxt.ik.x1     = pick_i.x1;
			rec_nxt.ik.x2     = pick_i.x2;
			rec_nxt.ik.info   = rec_i.forward_i + 1'b1;  // widened to a word first
			rec_nxt.forward_i = rec_i.forward_i + 1'b1;  // next iteration
		end
	end

	always_ff @(posedge Clk_32UI) begin
		rec_o <= rec_nxt;
		if (!reset_BWT_extend) begin
			rec_o.status <= bwt_pkg::DONE;
		end
	end

endmodule

`default_nettype wire

// ==== source/hit_check_stage.sv ====
`default_nettype none

module hit_check_stage (
	input  wire                     Clk_32UI,
	input  wire                     reset_BWT_extend, // sync, active low
	input  bwt_pkg::ext_rec_t       rec_i,
	input  bwt_pkg::cand_set_t      cand_i,
	output bwt_pkg::ext_rec_t       rec_o,
	output bwt_pkg::cand_t          pick_o,   // chosen candidate
	output logic                    update_o, // replace ik and advance i
	output bwt_pkg::curr_wr_t       curr_o    // curr queue port 1
);

	logic [1:0]         sel;      // complemented base
	bwt_pkg::cand_t     pick;
	bwt_pkg::ext_rec_t  rec_nxt;
	bwt_pkg::curr_wr_t  wr_nxt;
	logic               upd_nxt;

	assign sel  = 2'd3 - rec_i.query[1:0]; // base 0 takes candidate 3
	assign pick = cand_i[sel];

	// ------------------------------------------------------------------
	// interval change test and break decision
	// ------------------------------------------------------------------
	always_comb begin
		rec_nxt = rec_i;
		wr_nxt  = '0;  // idle write
		upd_nxt = 1'b0;
		if (rec_i.status == bwt_pkg::F_RUN) begin
			if (rec_i.query > 8'd3) begin
				wr_nxt.we        = 1'b1;                 // ambiguous base, store and stop
				wr_nxt.addr      = rec_i.ptr_curr;
				wr_nxt.data      = rec_i.ik;
				rec_nxt.ptr_curr = rec_i.ptr_curr + 1'b1;
				rec_nxt.status   = bwt_pkg::F_BREAK;
			end else if (pick.x2 != rec_i.ik.x2) begin
				wr_nxt.we        = 1'b1;                 // interval shrank, keep old one
				wr_nxt.addr      = rec_i.ptr_curr;
				wr_nxt.data      = rec_i.ik;
				rec_nxt.ptr_curr = rec_i.ptr_curr + 1'b1;
				if (pick.x2 < rec_i.min_intv) begin
					rec_nxt.status = bwt_pkg::F_BREAK;   // too few hits left
				end else begin
					upd_nxt = 1'b1;                      // take the new interval
				end
			end
			// equal size means no write and no update
		end
	end

	always_ff @(posedge Clk_32UI) begin
		rec_o <= rec_nxt;
		if (!reset_BWT_extend) begin
			rec_o.status <= bwt_pkg::DONE;
		end
	end

	// control outputs cleared in reset
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			curr_o   <= '0;
			update_o <= 1'b0;
		end else begin
			curr_o   <= wr_nxt;
			update_o <= upd_nxt;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		pick_o <= pick; // used one stage later
	end

endmodule

`default_nettype wire

// ==== source/fwd_entry_stage.sv ====
`default_nettype none

module fwd_entry_stage #(
	parameter int unsigned READ_LEN = 101 // read length in bases
) (
	input  wire                     Clk_32UI,
	input  wire                     reset_BWT_extend, // sync, active low
	input  bwt_pkg::ext_rec_t       rec_i,
	input  bwt_pkg::cand_set_t      cand_i,
	output bwt_pkg::ext_rec_t       rec_o,
	output bwt_pkg::cand_set_t      cand_o
);

	bwt_pkg::ext_rec_t rec_nxt; // record after the bound check

	// ------------------------------------------------------------------
	// iteration bound against read length
	// ------------------------------------------------------------------
	always_comb begin
		rec_nxt = rec_i; // everything else passes as is
		if (rec_i.status == bwt_pkg::F_RUN) begin
			if (rec_i.forward_i >= READ_LEN) begin
				rec_nxt.status = bwt_pkg::F_BREAK; // ran off the end of the read
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		rec_o <= rec_nxt;                      // payload moves every cycle
		if (!reset_BWT_extend) begin
			rec_o.status <= bwt_pkg::DONE;     // slot empty
		end
	end

	// candidates travel next to their record
	always_ff @(posedge Clk_32UI) begin
		cand_o <= cand_i; // aligned with rec_o
	end

endmodule

`default_nettype wire

// ==== source/bwt_pkg.sv ====
`default_nettype none

package bwt_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int IDX_W      = 7;  // iteration index, min interval, queue pointer
	localparam int QUERY_W    = 8;  // one query base
	localparam int READ_NUM_W = 10; // read number
	localparam int ADDR_W     = 32; // dram word address
	localparam int WORD_W     = 64; // one interval word

	// search status carried with every record
	typedef enum logic [5:0] {
		F_INIT  = 6'd0,  // first forward step, no extension yet
		F_RUN   = 6'd1,  // forward extension in progress
		F_BREAK = 6'd2,  // forward search stopped
		B_INIT  = 6'd3,  // handed on to the backward phase
		B_RUN   = 6'd4,  // backward phase, passed through here
		DONE    = 6'h3f  // empty slot
	} fwd_status_e;

	// ------------------------------------------------------------------
	// interval and candidate words
	// ------------------------------------------------------------------
	typedef struct packed {
		logic [WORD_W-1:0] info; // msb word of the queue entry
		logic [WORD_W-1:0] x2;   // interval size
		logic [WORD_W-1:0] x1;   // reverse start
		logic [WORD_W-1:0] x0;   // forward start
	} bi_interval_t;             // also the current queue data word

	typedef struct packed {
		logic [WORD_W-1:0] x2;
		logic [WORD_W-1:0] x1;
		logic [WORD_W-1:0] x0;
	} cand_t;                    // one extended interval, no info

	typedef cand_t [3:0] cand_set_t; // indexed by base

	// search record moving down the pipe
	typedef struct packed {
		fwd_status_e            status;
		logic [QUERY_W-1:0]     query;     // current base only
		logic [IDX_W-1:0]       ptr_curr;  // next free slot in curr queue
		logic [READ_NUM_W-1:0]  read_num;
		bi_interval_t           ik;
		logic [IDX_W-1:0]       forward_i; // iteration index
		logic [IDX_W-1:0]       min_intv;  // break threshold
	} ext_rec_t;

	typedef struct packed {
		logic               we;
		logic [IDX_W-1:0]   addr;
		bi_interval_t       data;
	} curr_wr_t;                 // curr queue write port

	typedef struct packed {
		logic               valid;
		logic [ADDR_W-1:0]  addr_k;
		logic [ADDR_W-1:0]  addr_l;
	} dram_req_t;                // occ table fetch for k and l

endpackage

`default_nettype wire
